// ==== filelist.f ====
source/phy_geometry_pkg.sv
source/afi_read_types_pkg.sv
source/afi_read_ctrl_if.sv
source/read_latency_fifo.sv
source/oct_read_window.sv
source/read_datapath.sv
testbench/read_datapath_sva.sv
testbench/tb_read_datapath.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_read_datapath
FILELIST := filelist.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_read_datapath.sv ====
// Testbench for the half-rate DDR2 read path checking read valid, termination window and data order

`default_nettype none

module tb_read_datapath;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int EXTRA_SHIFT = 1;
	localparam int T_RL        = 6;

	// Termination window edges as stated for the memory read latency
	localparam int ON_DELAY  = (T_RL - 4) / 2;
	localparam int OFF_DELAY = (T_RL + 6) / 2;

	logic                            pll_afi_clk;
	logic                            reset_n_afi_clk;
	afi_read_types_pkg::afi_phase_t  afi_rdata_en_i;
	afi_read_types_pkg::afi_phase_t  afi_rdata_en_full_i;
	afi_read_types_pkg::read_lat_t   seq_read_latency_i;
	afi_read_types_pkg::ddio_dq_t    ddio_phy_dq_i;
	afi_read_types_pkg::afi_rdata_t  afi_rdata_o;
	afi_read_types_pkg::afi_phase_t  afi_rdata_valid_o;
	afi_read_types_pkg::oct_ctrl_t   force_oct_off_o;

	integer seed;
	int errors;
	int checks;
	int base;

	// Bit 0 holds the enable sampled at the latest edge, bit n the one n edges earlier
	logic [63:0] en_h;
	logic [63:0] full_h;

	// Latency the sequencer applies with the next drive
	afi_read_types_pkg::read_lat_t lat_req;

	read_datapath #(
		.EXTRA_RDATA_EN_SHIFT (EXTRA_SHIFT),
		.MEM_T_RL             (T_RL)
	) dut0 (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_i      (afi_rdata_en_i),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.seq_read_latency_i  (seq_read_latency_i),
		.ddio_phy_dq_i       (ddio_phy_dq_i),
		.afi_rdata_o         (afi_rdata_o),
		.afi_rdata_valid_o   (afi_rdata_valid_o),
		.force_oct_off_o     (force_oct_off_o)
	);

	always #2 pll_afi_clk = ~pll_afi_clk;

	// **********************************************************************
	// Reference model and checking
	// **********************************************************************

	// Beat of group g in slot t moves from g * 4 + t to t * 2 + g
	function automatic afi_read_types_pkg::afi_rdata_t reorder(
		input afi_read_types_pkg::ddio_dq_t din);
		afi_read_types_pkg::afi_rdata_t dout;
		dout = '0;
		for (int g = 0; g < phy_geometry_pkg::MEM_READ_DQS_WIDTH; g++)
		begin
			for (int t = 0; t < phy_geometry_pkg::NUM_TIMESLOTS; t++)
			begin
				dout[(t * 2 + g) * 8 +: 8] = din[(g * 4 + t) * 8 +: 8];
			end
		end
		return dout;
	endfunction

	// Returns one with a chance of one in rate, never when rate is zero
	function automatic logic pick(input int rate);
		logic hit;
		hit = 1'b0;
		if (rate > 0)
			hit = (({$random(seed)} % rate) == 0);
		return hit;
	endfunction

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// One AFI cycle that logs what the edge sampled, drives new inputs and checks at mid cycle
	task automatic step(input int en_rate, input int full_rate);
		int dly;
		logic [1:0] exp_valid;
		logic [1:0] exp_force;
		@(posedge pll_afi_clk);
		en_h = {en_h[62:0], afi_rdata_en_i[0]};
		full_h = {full_h[62:0], afi_rdata_en_full_i[0]};
		#1;
		afi_rdata_en_i = {2{pick(en_rate)}};
		afi_rdata_en_full_i = {2{pick(full_rate)}};
		seq_read_latency_i = lat_req;
		ddio_phy_dq_i = {$random(seed), $random(seed)};
		#1;
		dly = EXTRA_SHIFT + int'(seq_read_latency_i) + 1;
		exp_valid = {2{en_h[dly]}};
		// The force bits drop while any full enable lies inside the window
		exp_force = {2{~(|full_h[OFF_DELAY:ON_DELAY])}};
		check("afi_rdata_valid_o", 64'(exp_valid), 64'(afi_rdata_valid_o));
		check("force_oct_off_o", 64'(exp_force), 64'(force_oct_off_o));
		check("afi_rdata_o", reorder(ddio_phy_dq_i), afi_rdata_o);
	endtask

	task automatic quiet(input int n);
		repeat (n) step(0, 0);
	endtask

	// Single read, then wait for valid and compare the measured delay
	task automatic measure_latency();
		int cnt;
		step(1, 0);
		step(0, 0);
		cnt = 0;
		while (afi_rdata_valid_o[0] !== 1'b1 && cnt < 64)
		begin
			step(0, 0);
			cnt++;
		end
		if (cnt >= 64)
		begin
			errors++;
			$display("Read valid did not arrive within 64 cycles of a single read");
		end
		else
			check("read valid delay", 64'(EXTRA_SHIFT + int'(lat_req) + 1), 64'(cnt));
	endtask

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial
	begin
		seed = 7;
		errors = 0;
		checks = 0;
		en_h = '0;
		full_h = '0;
		lat_req = '0;
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		afi_rdata_en_i = '0;
		afi_rdata_en_full_i = '0;
		seq_read_latency_i = '0;
		ddio_phy_dq_i = '0;
		repeat (5) @(posedge pll_afi_clk);
		#1;
		reset_n_afi_clk = 1'b1;
		#1;
		base = errors;
		check("afi_rdata_valid_o", '0, 64'(afi_rdata_valid_o));
		check("force_oct_off_o", '0, 64'(force_oct_off_o));
		$display("Test 1 reset values: %0d errors", errors - base);

		// Sparse reads give isolated and back-to-back enables
		base = errors;
		lat_req = 5'($random(seed));
		quiet(40);
		measure_latency();
		repeat (300) step(3, 4);
		$display("Test 2 random reads at latency %0d: %0d errors", lat_req, errors - base);

		// Latency only changes after the shifters have drained
		base = errors;
		for (int i = 0; i < 3; i++)
		begin
			quiet(40);
			lat_req = (i == 0) ? 5'd0 : (i == 1) ? 5'd31 : 5'($random(seed));
			measure_latency();
			repeat (200) step(3, 4);
		end
		$display("Test 3 latency changes: %0d errors", errors - base);

		base = errors;
		repeat (300) step(0, 8);
		repeat (100) step(0, 2);
		$display("Test 4 termination window: %0d errors", errors - base);

		base = errors;
		repeat (200) step(2, 2);
		$display("Test 5 data reordering: %0d errors", errors - base);

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/read_datapath_sva.sv ====
// Assertions on the read valid and termination outputs of the read path

`default_nettype none

module read_datapath_sva (
	input wire                                  pll_afi_clk,
	input wire                                  reset_n_afi_clk,
	input wire afi_read_types_pkg::afi_phase_t  afi_rdata_valid_o,
	input wire afi_read_types_pkg::oct_ctrl_t   force_oct_off_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// **********************************************************************
	// Output consistency
	// **********************************************************************

	// Both phases of a half-rate burst are valid together
	valid_phases_match: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o[1] == afi_rdata_valid_o[0])
		else $error("Read valid phases differ: %b", afi_rdata_valid_o);

	// Every DQS group shares one termination window
	force_groups_match: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		force_oct_off_o == {phy_geometry_pkg::AFI_DQS_WIDTH{force_oct_off_o[0]}})
		else $error("Termination override differs between groups: %b", force_oct_off_o);

	// Outputs held low for as long as reset is asserted
	reset_outputs_low: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> (afi_rdata_valid_o == '0 && force_oct_off_o == '0))
		else $error("Outputs not low during reset");

endmodule

bind read_datapath read_datapath_sva u_read_datapath_sva (
	.pll_afi_clk       (pll_afi_clk),
	.reset_n_afi_clk   (reset_n_afi_clk),
	.afi_rdata_valid_o (afi_rdata_valid_o),
	.force_oct_off_o   (force_oct_off_o)
);

`default_nettype wire

// ==== source/read_datapath.sv ====
// Half-rate DDR2 read path top level with data reordering, read valid and termination control

`default_nettype none

module read_datapath #(
	parameter int EXTRA_RDATA_EN_SHIFT = 1,
	parameter int MEM_T_RL             = 6
) (
	input  wire                             pll_afi_clk,
	input  wire                             reset_n_afi_clk,
	input  afi_read_types_pkg::afi_phase_t  afi_rdata_en_i,
	input  afi_read_types_pkg::afi_phase_t  afi_rdata_en_full_i,
	input  afi_read_types_pkg::read_lat_t   seq_read_latency_i,
	input  afi_read_types_pkg::ddio_dq_t    ddio_phy_dq_i,
	output afi_read_types_pkg::afi_rdata_t  afi_rdata_o,
	output afi_read_types_pkg::afi_phase_t  afi_rdata_valid_o,
	output afi_read_types_pkg::oct_ctrl_t   force_oct_off_o
);

	// **********************************************************************
	// Read control bundle
	// **********************************************************************

	afi_read_ctrl_if ctrl_if ();

	assign ctrl_if.rdata_en      = afi_rdata_en_i;
	assign ctrl_if.rdata_en_full = afi_rdata_en_full_i;
	assign ctrl_if.read_latency  = seq_read_latency_i;

	assign afi_rdata_valid_o = ctrl_if.rdata_valid;

	// Read enable to read valid through the programmable latency
	read_latency_fifo #(
		.EXTRA_RDATA_EN_SHIFT (EXTRA_RDATA_EN_SHIFT),
		.MAX_READ_LATENCY     (phy_geometry_pkg::MAX_READ_LATENCY)
	) u_read_latency_fifo (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.ctrl            (ctrl_if.latency_mp)
	);

	// Termination override derived from the memory read latency
	oct_read_window #(
		.MEM_T_RL (MEM_T_RL)
	) u_oct_read_window (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.ctrl            (ctrl_if.oct_mp),
		.force_oct_off_o (force_oct_off_o)
	);

	// **********************************************************************
	// Data reordering
	// **********************************************************************

	// The capture FIFOs in the I/O cells already deliver data on the AFI
	// clock, so only the beat order changes here
	// Input is group-major, output is timeslot-major
	generate
		for (genvar g = 0; g < phy_geometry_pkg::MEM_READ_DQS_WIDTH; g++)
		begin : g_group
			for (genvar t = 0; t < phy_geometry_pkg::NUM_TIMESLOTS; t++)
			begin : g_slot
				afi_read_types_pkg::dq_beat_t beat;

				// Beat of group g in slot t
				assign beat = ddio_phy_dq_i[(g * phy_geometry_pkg::NUM_TIMESLOTS + t) *
					phy_geometry_pkg::DQ_GROUP_WIDTH +: phy_geometry_pkg::DQ_GROUP_WIDTH];

				// Same beat placed in its timeslot lane
				assign afi_rdata_o[(t * phy_geometry_pkg::MEM_READ_DQS_WIDTH + g) *
					phy_geometry_pkg::DQ_GROUP_WIDTH +: phy_geometry_pkg::DQ_GROUP_WIDTH] = beat;
			end
		end
	endgenerate

endmodule

`default_nettype wire

// ==== source/oct_read_window.sv ====
// On-chip termination window that forces termination off around each read burst

`default_nettype none

module oct_read_window #(
	parameter int MEM_T_RL = 6
) (
	input  wire                            pll_afi_clk,
	input  wire                            reset_n_afi_clk,
	afi_read_ctrl_if.oct_mp                ctrl,
	output afi_read_types_pkg::oct_ctrl_t  force_oct_off_o
);

	// Cycles after the read enable at which termination must be switched on
	localparam int OCT_ON_DELAY = (MEM_T_RL - 4) / 2;

	// Cycles after the read enable at which termination may be released
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// **********************************************************************
	// Read enable history
	// **********************************************************************

	// Bit n holds the full read enable sampled n + 1 edges ago
	logic [OCT_OFF_DELAY-1:0] en_hist;

	// History with the current enable appended as tap 0
	logic [OCT_OFF_DELAY:0] en_taps;

	// High while any read sits inside the termination window
	logic read_window;

	assign en_taps = {en_hist, ctrl.rdata_en_full[0]};

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist <= '0;
		end
		else
		begin
			en_hist <= en_taps[OCT_OFF_DELAY-1:0];
		end
	end

	// The window spans the taps from the on delay up to the off delay
	assign read_window = |en_taps[OCT_OFF_DELAY:OCT_ON_DELAY];

	// All DQS groups share the same window
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			force_oct_off_o <= '0;
		end
		else
		begin
			force_oct_off_o <= {phy_geometry_pkg::AFI_DQS_WIDTH{~read_window}};
		end
	end

endmodule

`default_nettype wire

// ==== source/read_latency_fifo.sv ====
// Read latency FIFO turning the AFI read enable into the delayed read valid strobe

`default_nettype none

module read_latency_fifo #(
	parameter int EXTRA_RDATA_EN_SHIFT = 1,
	parameter int MAX_READ_LATENCY     = 32
) (
	input  wire                        pll_afi_clk,
	input  wire                        reset_n_afi_clk,
	afi_read_ctrl_if.latency_mp        ctrl
);

	// **********************************************************************
	// Extra read enable delay
	// **********************************************************************

	// Read enable after the fixed extra delay
	logic rdata_en_dly;

	// Capture FIFOs sit in the I/O cells, so only phase 0 of the
	// enable is needed to time the whole half-rate burst
	generate
		if (EXTRA_RDATA_EN_SHIFT > 0)
		begin : g_extra_shift
			logic [EXTRA_RDATA_EN_SHIFT-1:0] extra_q;
			logic [EXTRA_RDATA_EN_SHIFT:0]   extra_next;

			// New enable enters at bit 0 and the oldest falls off the top
			assign extra_next = {extra_q, ctrl.rdata_en[0]};

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
			begin
				if (!reset_n_afi_clk)
				begin
					extra_q <= '0;
				end
				else
				begin
					extra_q <= extra_next[EXTRA_RDATA_EN_SHIFT-1:0];
				end
			end

			assign rdata_en_dly = extra_q[EXTRA_RDATA_EN_SHIFT-1];
		end
		else
		begin : g_no_shift
			// No extra delay requested
			assign rdata_en_dly = ctrl.rdata_en[0];
		end
	endgenerate

	// **********************************************************************
	// Latency shifter and valid selection
	// **********************************************************************

	// Bit n holds the enable seen n cycles after it entered the shifter
	logic [MAX_READ_LATENCY-1:0] lat_shift;

	// Tap picked by the sequencer latency
	logic lat_tap;

	// Shift every cycle so several reads can be in flight together
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			lat_shift <= '0;
		end
		else
		begin
			lat_shift <= {lat_shift[MAX_READ_LATENCY-2:0], rdata_en_dly};
		end
	end

	assign lat_tap = lat_shift[ctrl.read_latency];

	// A half-rate burst fills both phases, hence the replicated tap
	// The register adds the final cycle of the total latency
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			ctrl.rdata_valid <= '0;
		end
		else
		begin
			ctrl.rdata_valid <= {phy_geometry_pkg::AFI_RATE_RATIO{lat_tap}};
		end
	end

endmodule

`default_nettype wire

// ==== source/afi_read_ctrl_if.sv ====
// Read control bundle between the read path top level and its control blocks

`default_nettype none

interface afi_read_ctrl_if;

	// Read enable from the controller, one bit per AFI phase
	afi_read_types_pkg::afi_phase_t rdata_en;

	// Full burst read enable, used for the termination window
	afi_read_types_pkg::afi_phase_t rdata_en_full;

	// Latency count chosen by the sequencer during calibration
	// It only changes while no read is in flight
	afi_read_types_pkg::read_lat_t read_latency;

	// Read valid strobe returned towards the controller
	afi_read_types_pkg::afi_phase_t rdata_valid;

	// Latency FIFO view which consumes the enables and produces valid
	modport latency_mp (
		input  rdata_en,
		input  rdata_en_full,
		input  read_latency,
		output rdata_valid
	);

	// Termination window view which only needs the full read enable
	modport oct_mp (
		input  rdata_en_full
	);

endinterface

`default_nettype wire

// ==== source/afi_read_types_pkg.sv ====
// Vector types for the AFI and DDIO read buses and the read latency count

`default_nettype none

package afi_read_types_pkg;

	// **********************************************************************
	// Data buses
	// **********************************************************************

	// Captured DDIO data, ordered by DQS group first
	// Within a group the four timeslots sit side by side, lowest slot first
	typedef logic [phy_geometry_pkg::AFI_DATA_WIDTH-1:0] ddio_dq_t;

	// AFI read data, ordered by timeslot first
	// Within a timeslot the groups sit side by side, group 0 lowest
	typedef logic [phy_geometry_pkg::AFI_DATA_WIDTH-1:0] afi_rdata_t;

	// One DQS group in one timeslot, the unit moved by the reordering
	typedef logic [phy_geometry_pkg::DQ_GROUP_WIDTH-1:0] dq_beat_t;

	// **********************************************************************
	// Control vectors
	// **********************************************************************

	// One bit per AFI phase, used for read enables and read valid
	typedef logic [phy_geometry_pkg::AFI_RATE_RATIO-1:0] afi_phase_t;

	// Read latency in AFI cycles as tuned by the sequencer
	typedef logic [phy_geometry_pkg::MAX_LATENCY_COUNT_WIDTH-1:0] read_lat_t;

	// Per DQS group termination override
	typedef logic [phy_geometry_pkg::AFI_DQS_WIDTH-1:0] oct_ctrl_t;

endpackage

`default_nettype wire

// ==== source/phy_geometry_pkg.sv ====
// Memory and AFI geometry constants shared by the half-rate DDR2 read path

`default_nettype none

package phy_geometry_pkg;

	// **********************************************************************
	// Memory side
	// **********************************************************************

	// Number of DQ pins on the memory bus
	localparam int MEM_DQ_WIDTH = 16;

	// Number of read DQS groups, each strobing its own slice of DQ
	localparam int MEM_READ_DQS_WIDTH = 2;

	// DQ bits covered by one DQS group
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / MEM_READ_DQS_WIDTH;

	// **********************************************************************
	// AFI side
	// **********************************************************************

	// Half rate gives two memory clock phases per AFI cycle
	localparam int AFI_RATE_RATIO = 2;

	// Each phase carries a rising and a falling beat, so four beats per AFI cycle
	localparam int NUM_TIMESLOTS = 2 * AFI_RATE_RATIO;

	// Full read data word handed to the controller in one AFI cycle
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// One termination control bit per DQS group
	localparam int AFI_DQS_WIDTH = MEM_READ_DQS_WIDTH;

	// **********************************************************************
	// Read latency
	// **********************************************************************

	// Width of the latency count driven by the sequencer
	localparam int MAX_LATENCY_COUNT_WIDTH = 5;

	// Depth of the latency shifter covers every count value
	localparam int MAX_READ_LATENCY = 2 ** MAX_LATENCY_COUNT_WIDTH;

endpackage

`default_nettype wire
